// File: verilog/imd_pkg.sv
// Shared widths, operation codes and command types of the multiply/divide unit
// Register width is fixed at 32 bits; HI occupies the upper half of dword_t
// Both sequential units need STEPS iterations plus one sign-fix cycle
package imd_pkg;

	localparam int REG_WIDTH = 32;	// Width of one general purpose register
	localparam int STEPS = REG_WIDTH;	// Iterations of the multiplier and of the divider
	localparam int CNT_WIDTH = $clog2(STEPS + 1);	// Step counter must hold STEPS down to zero

	typedef logic [REG_WIDTH-1:0] reg_t;	// One register word
	typedef logic [2*REG_WIDTH-1:0] dword_t;	// HI:LO pair, HI in the upper word

	// Primary opcode of the register-register instruction class
	localparam logic [5:0] OPC_SPECIAL = 6'h00;

	// Function field codes of the SPECIAL class handled here
	localparam logic [5:0] FN_MFHI = 6'h10;	// Move from HI
	localparam logic [5:0] FN_MTHI = 6'h11;	// Move to HI
	localparam logic [5:0] FN_MFLO = 6'h12;	// Move from LO
	localparam logic [5:0] FN_MTLO = 6'h13;	// Move to LO
	localparam logic [5:0] FN_MULT = 6'h18;	// Signed multiply
	localparam logic [5:0] FN_MULTU = 6'h19;	// Unsigned multiply
	localparam logic [5:0] FN_DIV = 6'h1A;	// Signed divide
	localparam logic [5:0] FN_DIVU = 6'h1B;	// Unsigned divide

	// Operation code handed from the decoder to the unit
	typedef enum logic [3:0] {
		IMD_NONE = 4'd0,	// Not an instruction for this unit
		IMD_MFHI = 4'd1,	// Read HI into rd
		IMD_MFLO = 4'd2,	// Read LO into rd
		IMD_MTHI = 4'd3,	// Write rs into HI
		IMD_MTLO = 4'd4,	// Write rs into LO
		IMD_MUL = 4'd5,	// Signed 32x32 multiply
		IMD_MULU = 4'd6,	// Unsigned 32x32 multiply
		IMD_DIV = 4'd7,	// Signed divide
		IMD_DIVU = 4'd8	// Unsigned divide
	} imd_op_e;

	// Decoded command entering the execute stage
	typedef struct packed {
		imd_op_e op;	// What to do
		reg_t rs_val;	// Dividend, multiplicand or the MT source
		reg_t rt_val;	// Divisor or multiplier
	} imd_cmd_t;

	// Register write produced by MFHI and MFLO
	typedef struct packed {
		logic valid;	// Val is to be written to rd
		reg_t val;	// HI or LO contents
	} imd_res_t;

endpackage

// File: verilog/imd_decode.sv
// Decoder from a raw instruction word to the multiply/divide operation code
// Purely combinational; only the SPECIAL class is recognised
// Unknown function codes and all other opcodes decode to IMD_NONE
module imd_decode (
	input  logic [31:0]       i_instr,	// Raw instruction word
	input  imd_pkg::reg_t     i_rs_val,	// Value of register rs
	input  imd_pkg::reg_t     i_rt_val,	// Value of register rt
	output imd_pkg::imd_cmd_t o_cmd	// Decoded command for the unit
);
	import imd_pkg::*;

	logic [5:0] opcode;	// Primary opcode field
	logic [5:0] funct;	// Function field of SPECIAL instructions
	imd_op_e op;	// Decoded operation

	assign opcode = i_instr[31:26];	// Top six bits select the instruction class
	assign funct = i_instr[5:0];	// Low six bits select the SPECIAL function

	always_comb
	begin
		op = IMD_NONE;	// Default covers every word the unit does not own
		if (opcode == OPC_SPECIAL)
		begin
			case (funct)
				FN_MFHI: op = IMD_MFHI;
				FN_MTHI: op = IMD_MTHI;
				FN_MFLO: op = IMD_MFLO;
				FN_MTLO: op = IMD_MTLO;
				FN_MULT: op = IMD_MUL;
				FN_MULTU: op = IMD_MULU;
				FN_DIV: op = IMD_DIV;
				FN_DIVU: op = IMD_DIVU;
				default: op = IMD_NONE;	// Shifts, jumps and ALU ops belong elsewhere
			endcase
		end
	end

	// Operands go through untouched, the unit latches them itself
	assign o_cmd = '{op: op, rs_val: i_rs_val, rt_val: i_rt_val};

	// A known instruction word must always give a legal operation code
	always_comb
	begin
		if (!$isunknown(i_instr))
		begin
			assert (!$isunknown(o_cmd.op) && (o_cmd.op <= IMD_DIVU))
			else
				$error("imd_decode: illegal op %0h for instruction %08h", o_cmd.op, i_instr);
		end
	end

endmodule

// File: verilog/long_imul.sv
// Sequential shift-and-add multiplier, one multiplier bit per clock
// Start is a single-cycle pulse accepted only while ready is high
// Ready drops after start and returns STEPS+1 cycles later with the product
// Signed products are formed from magnitudes and negated at the end
module long_imul (
	input  logic            clk,
	input  logic            nrst,
	input  imd_pkg::reg_t   i_multiplicand,	// First operand, sampled on start
	input  imd_pkg::reg_t   i_multiplier,	// Second operand, sampled on start
	input  logic            i_start,	// One-cycle start pulse
	input  logic            i_signd,	// Operands are two's complement
	output logic            o_ready,	// Idle, product valid after a run
	output imd_pkg::dword_t o_product	// Full 64-bit product
);
	import imd_pkg::*;

	logic [CNT_WIDTH-1:0] cnt;	// Remaining add steps
	logic neg;	// Product must be negated at the end
	reg_t mag_a;	// Magnitude of the multiplicand
	reg_t mag_b;	// Magnitude of the multiplier
	dword_t mcand;	// Multiplicand shifted left each step
	reg_t mplier;	// Multiplier shifted right each step
	dword_t acc;	// Partial product

	// Take the absolute value only for signed operation
	assign mag_a = (i_signd && i_multiplicand[REG_WIDTH-1]) ? -i_multiplicand : i_multiplicand;
	assign mag_b = (i_signd && i_multiplier[REG_WIDTH-1]) ? -i_multiplier : i_multiplier;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			o_ready <= 1'b1;	// Idle out of reset
			cnt <= '0;
			neg <= 1'b0;
		end
		else if (i_start)
		begin
			o_ready <= 1'b0;	// Busy from the next cycle on
			cnt <= CNT_WIDTH'(STEPS);
			neg <= i_signd && (i_multiplicand[REG_WIDTH-1] ^ i_multiplier[REG_WIDTH-1]);
		end
		else if (!o_ready)
		begin
			if (cnt != '0)
				cnt <= cnt - 1'b1;	// One multiplier bit consumed
			else
				o_ready <= 1'b1;	// Sign fix done this cycle
		end
	end

	always_ff @(posedge clk)
	begin
		if (i_start)
		begin
			mcand <= dword_t'(mag_a);	// Zero extended into the low word
			mplier <= mag_b;
			acc <= '0;
		end
		else if (!o_ready && (cnt != '0))
		begin
			if (mplier[0])
				acc <= acc + mcand;	// Add the weighted multiplicand for a set bit
			mcand <= mcand << 1;
			mplier <= mplier >> 1;
		end
		else if (!o_ready)
			o_product <= neg ? -acc : acc;	// Restore the sign of the result
	end

	// The control unit never restarts a run in progress
	assert property (@(posedge clk) disable iff (!nrst) i_start |-> o_ready)
	else
		$error("long_imul: start while busy");

endmodule

// File: verilog/long_idiv.sv
// Sequential restoring divider, one quotient bit per clock
// Start is a single-cycle pulse accepted only while ready is high
// Ready drops after start and returns STEPS+1 cycles later
// Result packs the remainder over the quotient, like HI over LO
// Signed division works on magnitudes; the quotient is negated when the
// signs differ and the remainder takes the sign of the dividend
// Division by zero yields an all-ones magnitude quotient and the dividend
// magnitude as remainder, both followed by the usual sign fix
module long_idiv (
	input  logic            clk,
	input  logic            nrst,
	input  imd_pkg::reg_t   i_dividend,	// Numerator, sampled on start
	input  imd_pkg::reg_t   i_divider,	// Denominator, sampled on start
	input  logic            i_start,	// One-cycle start pulse
	input  logic            i_signd,	// Operands are two's complement
	output logic            o_ready,	// Idle, result valid after a run
	output imd_pkg::dword_t o_remquot	// Remainder in the upper word, quotient in the lower
);
	import imd_pkg::*;

	logic [CNT_WIDTH-1:0] cnt;	// Remaining subtract steps
	logic neg_q;	// Quotient must be negated
	logic neg_r;	// Remainder must be negated
	reg_t mag_n;	// Magnitude of the dividend
	reg_t mag_d;	// Magnitude of the divider
	reg_t dvs;	// Latched divider magnitude
	reg_t quot;	// Dividend bits shift out at the top, quotient bits in at the bottom
	reg_t rem;	// Partial remainder
	logic [REG_WIDTH:0] rem_sh;	// Partial remainder with the next dividend bit appended
	logic [REG_WIDTH:0] diff;	// Trial subtraction, negative when the top bit is set

	assign mag_n = (i_signd && i_dividend[REG_WIDTH-1]) ? -i_dividend : i_dividend;
	assign mag_d = (i_signd && i_divider[REG_WIDTH-1]) ? -i_divider : i_divider;

	assign rem_sh = {rem, quot[REG_WIDTH-1]};	// Bring down the next dividend bit
	assign diff = rem_sh - {1'b0, dvs};	// Extra bit keeps the borrow visible

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			o_ready <= 1'b1;	// Idle out of reset
			cnt <= '0;
			neg_q <= 1'b0;
			neg_r <= 1'b0;
		end
		else if (i_start)
		begin
			o_ready <= 1'b0;
			cnt <= CNT_WIDTH'(STEPS);
			neg_q <= i_signd && (i_dividend[REG_WIDTH-1] ^ i_divider[REG_WIDTH-1]);
			neg_r <= i_signd && i_dividend[REG_WIDTH-1];
		end
		else if (!o_ready)
		begin
			if (cnt != '0)
				cnt <= cnt - 1'b1;	// One quotient bit resolved
			else
				o_ready <= 1'b1;	// Sign fix done this cycle
		end
	end

	always_ff @(posedge clk)
	begin
		if (i_start)
		begin
			quot <= mag_n;
			dvs <= mag_d;
			rem <= '0;
		end
		else if (!o_ready && (cnt != '0))
		begin
			if (!diff[REG_WIDTH])
			begin
				rem <= diff[REG_WIDTH-1:0];	// Divider fits, keep the difference
				quot <= {quot[REG_WIDTH-2:0], 1'b1};
			end
			else
			begin
				rem <= rem_sh[REG_WIDTH-1:0];	// Restore, the divider did not fit
				quot <= {quot[REG_WIDTH-2:0], 1'b0};
			end
		end
		else if (!o_ready)
			o_remquot <= {(neg_r ? -rem : rem), (neg_q ? -quot : quot)};
	end

	// The control unit never restarts a run in progress
	assert property (@(posedge clk) disable iff (!nrst) i_start |-> o_ready)
	else
		$error("long_idiv: start while busy");

endmodule

// File: verilog/imuldivu.sv
// Integer multiply and divide unit with the HI/LO register pair
// Three stages follow the core pipeline: execute, memory and writeback
// MFHI/MFLO results appear on o_rd the cycle after acceptance
// MTHI/MTLO reach HI:LO two unstalled edges after acceptance, so an MF
// needs at least two unrelated slots after an MT to see the new value
// A finishing multiply or divide wins over a pending MT in writeback
// While a run is active, MF and new MUL/DIV commands raise o_exec_stall
module imuldivu (
	input  logic              clk,
	input  logic              nrst,
	input  imd_pkg::imd_cmd_t i_cmd,	// Decoded command of the execute stage
	input  logic              i_mem_stall,	// Memory stage holds the pipeline
	input  logic              i_fetch_stall,	// Fetch stage holds the pipeline
	output logic              o_exec_stall,	// Execute stage waits for a run to finish
	output imd_pkg::imd_res_t o_rd	// MF result for the register file
);
	import imd_pkg::*;

	logic core_stall;	// Any stall source, nothing advances
	logic interlock_op;	// Present op depends on or would disturb HI:LO
	dword_t hilo;	// HI in the upper word, LO in the lower

	logic mul_running;	// Multiply launched and not yet written back
	logic mul_start;	// Start pulse to the multiplier
	logic mul_signd;	// Signed multiply
	logic mul_ready;	// Multiplier idle or finished
	logic mul_done;	// Multiply result is written this cycle
	dword_t mul_product;

	logic div_running;	// Divide launched and not yet written back
	logic div_start;	// Start pulse to the divider
	logic div_signd;	// Signed divide
	logic div_ready;	// Divider idle or finished
	logic div_done;	// Divide result is written this cycle
	dword_t div_remquot;

	reg_t rs_reg;	// Operands held for the sequential units
	reg_t rt_reg;

	logic mthi_p2;	// MT write in the memory stage
	logic mtlo_p2;
	reg_t rval_p2;
	logic mthi_p3;	// MT write in the writeback stage
	logic mtlo_p3;
	reg_t rval_p3;

	logic rd_valid;	// MF result register
	reg_t rd_val;

	assign interlock_op = i_cmd.op inside {IMD_MFHI, IMD_MFLO, IMD_MUL, IMD_MULU, IMD_DIV, IMD_DIVU};
	// External stalls take precedence so the stall sources never overlap
	assign o_exec_stall = !i_mem_stall && !i_fetch_stall && (mul_running || div_running) &&
		interlock_op;
	assign core_stall = o_exec_stall || i_mem_stall || i_fetch_stall;

	// Ready is still high in the start cycle, the start pulse masks it
	assign mul_done = mul_running && mul_ready && !mul_start;
	assign div_done = div_running && div_ready && !div_start;

	assign o_rd = '{valid: rd_valid, val: rd_val};

	// Execute stage
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			rd_valid <= 1'b0;
			rd_val <= '0;
			mthi_p2 <= 1'b0;
			mtlo_p2 <= 1'b0;
			mul_running <= 1'b0;
			mul_start <= 1'b0;
			mul_signd <= 1'b0;
			div_running <= 1'b0;
			div_start <= 1'b0;
			div_signd <= 1'b0;
		end
		else
		begin
			mul_start <= 1'b0;	// Start is a single-cycle pulse
			div_start <= 1'b0;
			if (mul_done)
				mul_running <= 1'b0;
			if (div_done)
				div_running <= 1'b0;
			if (!core_stall)
			begin
				rd_valid <= 1'b0;	// Cleared unless a new MF arrives
				mthi_p2 <= 1'b0;
				mtlo_p2 <= 1'b0;
				case (i_cmd.op)
					IMD_MFHI:
					begin
						rd_valid <= 1'b1;
						rd_val <= hilo[2*REG_WIDTH-1:REG_WIDTH];
					end
					IMD_MFLO:
					begin
						rd_valid <= 1'b1;
						rd_val <= hilo[REG_WIDTH-1:0];
					end
					IMD_MTHI: mthi_p2 <= 1'b1;
					IMD_MTLO: mtlo_p2 <= 1'b1;
					IMD_MUL, IMD_MULU:
					begin
						mul_start <= 1'b1;
						mul_running <= 1'b1;
						mul_signd <= (i_cmd.op == IMD_MUL);
					end
					IMD_DIV, IMD_DIVU:
					begin
						div_start <= 1'b1;
						div_running <= 1'b1;
						div_signd <= (i_cmd.op == IMD_DIV);
					end
					default: ;	// Not for this unit
				endcase
			end
		end
	end

	// Operand and MT data registers of the execute and memory stages
	always_ff @(posedge clk)
	begin
		if (!core_stall)
		begin
			if (i_cmd.op inside {IMD_MUL, IMD_MULU, IMD_DIV, IMD_DIVU})
			begin
				rs_reg <= i_cmd.rs_val;
				rt_reg <= i_cmd.rt_val;
			end
			if (i_cmd.op inside {IMD_MTHI, IMD_MTLO})
				rval_p2 <= i_cmd.rs_val;	// MT source is always rs
			rval_p3 <= rval_p2;
		end
	end

	// Memory stage
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			mthi_p3 <= 1'b0;
			mtlo_p3 <= 1'b0;
		end
		else if (!core_stall)
		begin
			mthi_p3 <= mthi_p2;
			mtlo_p3 <= mtlo_p2;
		end
	end

	// Writeback stage, a finishing run ignores the pipeline stall
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			hilo <= '0;
		else if (mul_done)
			hilo <= mul_product;
		else if (div_done)
			hilo <= div_remquot;	// Remainder lands in HI, quotient in LO
		else if (!core_stall)
		begin
			if (mthi_p3)
				hilo[2*REG_WIDTH-1:REG_WIDTH] <= rval_p3;
			if (mtlo_p3)
				hilo[REG_WIDTH-1:0] <= rval_p3;
		end
	end

	long_imul u_imul (
		.clk(clk),
		.nrst(nrst),
		.i_multiplicand(rs_reg),
		.i_multiplier(rt_reg),
		.i_start(mul_start),
		.i_signd(mul_signd),
		.o_ready(mul_ready),
		.o_product(mul_product)
	);

	long_idiv u_idiv (
		.clk(clk),
		.nrst(nrst),
		.i_dividend(rs_reg),
		.i_divider(rt_reg),
		.i_start(div_start),
		.i_signd(div_signd),
		.o_ready(div_ready),
		.o_remquot(div_remquot)
	);

	// The interlock keeps a second run from starting until the first is written back
	assert property (@(posedge clk) disable iff (!nrst) !(mul_running && div_running))
	else
		$error("imuldivu: multiply and divide running together");

	// An MF is only accepted with no run active, so its result never meets a stall
	assert property (@(posedge clk) disable iff (!nrst) !(o_rd.valid && o_exec_stall))
	else
		$error("imuldivu: rd valid during execute stall");

endmodule

// File: verilog/imuldiv_top.sv
// Multiply/divide block as seen by the core: decoder plus execution unit
// Operands arrive already read from the register file and forwarded
// The environment must hold all inputs while any stall is high
module imuldiv_top (
	input  logic              clk,
	input  logic              nrst,
	input  logic [31:0]       i_instr,	// Instruction in the execute stage
	input  imd_pkg::reg_t     i_rs_val,	// Forwarded rs value
	input  imd_pkg::reg_t     i_rt_val,	// Forwarded rt value
	input  logic              i_mem_stall,	// Stall level from the memory stage
	input  logic              i_fetch_stall,	// Stall level from the fetch stage
	output logic              o_exec_stall,	// Stall request of this unit
	output imd_pkg::imd_res_t o_rd	// MFHI/MFLO register write
);
	import imd_pkg::*;

	imd_cmd_t cmd;	// Decoded command into the unit

	imd_decode u_decode (
		.i_instr(i_instr),
		.i_rs_val(i_rs_val),
		.i_rt_val(i_rt_val),
		.o_cmd(cmd)
	);

	imuldivu u_imuldivu (
		.clk(clk),
		.nrst(nrst),
		.i_cmd(cmd),
		.i_mem_stall(i_mem_stall),
		.i_fetch_stall(i_fetch_stall),
		.o_exec_stall(o_exec_stall),
		.o_rd(o_rd)
	);

endmodule

// File: test/tb_imuldiv.sv
// Testbench for the multiply/divide block, driving imuldiv_top as u_dut
// Inputs change on the rising edge, outputs are sampled on the falling edge
// A reference model mirrors HI and LO and computes products and quotients
// The first mismatch ends the run, a watchdog bounds the total time
module tb_imuldiv;
	timeunit 1ns;
	timeprecision 100ps;
	import imd_pkg::*;

	localparam int N_CORNER = 6;	// Corner operand pairs per operation
	localparam int N_RAND = 10;	// Random operand pairs per operation
	localparam int N_STALL = 12;	// Operations run under random external stalls
	localparam int N_OPS = 4 * (N_CORNER + N_RAND) + N_STALL;
	localparam int N_TESTS = 3 * N_OPS + 24;	// Each op is issued, then read back twice

	logic clk;
	logic nrst;
	logic [31:0] i_instr;
	reg_t i_rs_val;
	reg_t i_rt_val;
	logic i_mem_stall;
	logic i_fetch_stall;
	logic o_exec_stall;
	imd_res_t o_rd;

	reg_t hi_m;	// Model of HI
	reg_t lo_m;	// Model of LO
	int seed = 32;	// Seed of every random draw
	logic stall_rand;	// External stalls are randomised when set

	// Zero, minus one and the most negative value in several pairings
	reg_t mul_ca [N_CORNER] = '{32'h0, 32'h0, 32'hffffffff, 32'h80000000, 32'h80000000, 32'h7fffffff};
	reg_t mul_cb [N_CORNER] = '{32'h0, 32'hffffffff, 32'hffffffff, 32'hffffffff, 32'h80000000,
		32'h80000000};
	// Divide by zero, most negative by minus one and mixed signs
	reg_t div_ca [N_CORNER] = '{32'h5, 32'hfffffff9, 32'h80000000, 32'hfffffff9, 32'h7, 32'h0};
	reg_t div_cb [N_CORNER] = '{32'h0, 32'h0, 32'hffffffff, 32'h2, 32'hfffffffe, 32'h0};

	imuldiv_top u_dut (
		.clk(clk),
		.nrst(nrst),
		.i_instr(i_instr),
		.i_rs_val(i_rs_val),
		.i_rt_val(i_rt_val),
		.i_mem_stall(i_mem_stall),
		.i_fetch_stall(i_fetch_stall),
		.o_exec_stall(o_exec_stall),
		.o_rd(o_rd)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;	// 40 ns period
	end

	// SPECIAL class word, the register fields are arbitrary filler
	function automatic logic [31:0] special(input logic [5:0] fn);
		return {6'h00, 5'd4, 5'd5, 5'd6, 5'd0, fn};
	endfunction

	// Low half of the product of the extended operands is the exact 64-bit result
	function automatic dword_t ref_mul(input reg_t a, input reg_t b, input logic signd);
		dword_t ea;
		dword_t eb;
		ea = signd ? {{REG_WIDTH{a[REG_WIDTH-1]}}, a} : {{REG_WIDTH{1'b0}}, a};
		eb = signd ? {{REG_WIDTH{b[REG_WIDTH-1]}}, b} : {{REG_WIDTH{1'b0}}, b};
		return ea * eb;
	endfunction

	// Remainder over quotient, magnitudes first and the sign fix afterwards
	function automatic dword_t ref_div(input reg_t n, input reg_t d, input logic signd);
		reg_t mn;
		reg_t md;
		reg_t q;
		reg_t r;
		mn = (signd && n[REG_WIDTH-1]) ? -n : n;
		md = (signd && d[REG_WIDTH-1]) ? -d : d;
		q = (md == '0) ? '1 : mn / md;	// Zero divider gives an all-ones quotient
		r = (md == '0) ? mn : mn % md;
		if (signd && (n[REG_WIDTH-1] ^ d[REG_WIDTH-1]))
			q = -q;
		if (signd && n[REG_WIDTH-1])
			r = -r;	// Remainder follows the dividend
		return {r, q};
	endfunction

	task automatic abort_run();
		$display("SIMULATION FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_rd(input string name, input imd_res_t got, input imd_res_t exp);
		if ((got.valid !== exp.valid) || (exp.valid && (got.val !== exp.val)))
		begin
			$display("** Error: %s got valid %h val %h, expected valid %h val %h", name,
				got.valid, got.val, exp.valid, exp.val);
			abort_run();
		end
	endtask

	task automatic check_stall(input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("** Error: o_exec_stall got %h, expected %h", got, exp);
			abort_run();
		end
	endtask

	// New stall levels for the coming cycle, roughly one in four each
	task automatic drive_stalls();
		i_mem_stall <= stall_rand && (({$random(seed)} % 4) == 0);
		i_fetch_stall <= stall_rand && (({$random(seed)} % 4) == 0);
	endtask

	// Called on a rising edge; returns on the edge that accepts the instruction
	task automatic issue(input logic [31:0] instr, input reg_t rs, input reg_t rt);
		logic stalled;
		i_instr <= instr;
		i_rs_val <= rs;
		i_rt_val <= rt;
		drive_stalls();
		stalled = 1'b1;
		while (stalled)
		begin
			@(negedge clk);
			stalled = o_exec_stall || i_mem_stall || i_fetch_stall;	// Decides the next edge
			@(posedge clk);
			if (stalled)
				drive_stalls();	// Instruction and operands stay put
		end
		i_instr <= '0;	// NOP until the next issue
		i_rs_val <= '0;
		i_rt_val <= '0;
	endtask

	task automatic read_reg(input logic [5:0] fn, input reg_t exp_val, input string name);
		imd_res_t exp;
		exp = '{valid: 1'b1, val: exp_val};
		issue(special(fn), '0, '0);
		@(negedge clk);
		check_rd(name, o_rd, exp);	// Result is present the cycle after acceptance
		@(posedge clk);
	endtask

	task automatic check_hilo();
		read_reg(FN_MFHI, hi_m, "o_rd after MFHI");
		read_reg(FN_MFLO, lo_m, "o_rd after MFLO");
	endtask

	task automatic write_hilo(input reg_t hi, input reg_t lo);
		issue(special(FN_MTHI), hi, '0);
		issue(special(FN_MTLO), lo, '0);
		issue('0, '0, '0);	// Two slots before the writes are visible
		issue('0, '0, '0);
		hi_m = hi;
		lo_m = lo;
		check_hilo();
	endtask

	task automatic run_muldiv(input logic [5:0] fn, input reg_t a, input reg_t b);
		dword_t r;
		issue(special(fn), a, b);
		case (fn)
			FN_MULT: r = ref_mul(a, b, 1'b1);
			FN_MULTU: r = ref_mul(a, b, 1'b0);
			FN_DIV: r = ref_div(a, b, 1'b1);
			default: r = ref_div(a, b, 1'b0);
		endcase
		{hi_m, lo_m} = r;
		check_hilo();	// MFHI waits in issue until o_exec_stall falls
	endtask

	// Instructions the unit does not own must leave HI, LO and rd alone
	task automatic check_ignored(input logic [31:0] instr);
		issue(instr, 32'h1, 32'h2);
		@(negedge clk);
		check_rd("o_rd after ignored instruction", o_rd, '{valid: 1'b0, val: '0});
		@(posedge clk);
	endtask

	// The unit never requests a stall while another stage already holds the core
	always @(negedge clk)
	begin
		if (nrst && (i_mem_stall || i_fetch_stall))
			check_stall(o_exec_stall, 1'b0);
	end

	initial
	begin
		#(N_TESTS * (STEPS + 8) * 40 + 2000);
		$display("Timeout: the tests did not finish in the time allowed");
		abort_run();
	end

	initial
	begin
		logic [5:0] fn;
		logic [5:0] ops [4];
		reg_t a;
		reg_t b;
		ops = '{FN_MULT, FN_MULTU, FN_DIV, FN_DIVU};
		nrst = 1'b0;
		i_instr = '0;
		i_rs_val = '0;
		i_rt_val = '0;
		i_mem_stall = 1'b0;
		i_fetch_stall = 1'b0;
		stall_rand = 1'b0;
		hi_m = '0;	// HI and LO clear on reset
		lo_m = '0;
		repeat (16) @(posedge clk);
		nrst <= 1'b1;
		@(negedge clk);
		check_stall(o_exec_stall, 1'b0);
		check_rd("o_rd after reset", o_rd, '{valid: 1'b0, val: '0});
		@(posedge clk);
		check_hilo();
		write_hilo(32'h12345678, 32'h9abcdef0);
		for (int i = 0; i < 2; i++)
		begin
			for (int k = 0; k < N_CORNER; k++)
				run_muldiv(ops[i], mul_ca[k], mul_cb[k]);
			for (int k = 0; k < N_CORNER; k++)
				run_muldiv(ops[i + 2], div_ca[k], div_cb[k]);
		end
		for (int i = 0; i < 4; i++)
		begin
			for (int k = 0; k < N_RAND; k++)
			begin
				a = $random(seed);
				b = $random(seed);
				if (k == 0)
					b = b >> 20;	// A small divider gives a wide quotient
				run_muldiv(ops[i], a, b);
			end
		end
		stall_rand = 1'b1;
		write_hilo(32'hcafef00d, 32'h0badbeef);	// MT path under stalls too
		for (int k = 0; k < N_STALL; k++)
		begin
			fn = ops[{$random(seed)} % 4];
			a = $random(seed);
			b = $random(seed);
			run_muldiv(fn, a, b);
		end
		stall_rand = 1'b0;
		check_ignored(special(6'h20));	// ADD is not a unit operation
		check_ignored({6'h08, 20'h12345, FN_MULT});	// Not SPECIAL despite the funct bits
		check_hilo();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: imuldiv.f
verilog/imd_pkg.sv
verilog/imd_decode.sv
verilog/long_imul.sv
verilog/long_idiv.sv
verilog/imuldivu.sv
verilog/imuldiv_top.sv
test/tb_imuldiv.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; the exit status reports pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f imuldiv.f --top-module tb_imuldiv \
	--Mdir obj_dir -o sim_imuldiv &&
./obj_dir/sim_imuldiv || exit 1
